// File: include/rf_macros.svh
// ========================================
// sizing of the banked register file
// changing a value assumes 32 entries total
// ========================================
`ifndef RF_MACROS_SVH
`define RF_MACROS_SVH

// storage split
`define RF_NUM_BANKS 4
`define RF_REGS_PER_BANK 8

// core operand ports, rs1 and rs2
`define RF_NUM_READ_PORTS 2

// apb byte address of the lock register
`define RF_LOCK_ADDR 8'h80

`endif

// File: logic/rf_pkg.sv
// ========================================
// vector types of the register file
// widths assume 32 entries in 4 banks
// ========================================
package rf_pkg;

  typedef logic [31:0] word_t;      // one register or apb data word

  typedef logic [4:0]  reg_idx_t;   // architectural index x0..x31

  typedef logic [2:0]  local_idx_t; // entry within a bank

  typedef logic [1:0]  bank_sel_t;  // upper index bits

  typedef logic [3:0]  byte_en_t;   // one enable per byte lane

  typedef logic [7:0]  apb_addr_t;  // apb byte address

  typedef logic [7:0]  lock_vec_t;  // lock bits of one bank

endpackage

// File: logic/apb_regif.sv
// ========================================
// zero wait state apb decode, no registers
// entries sit at word aligned 0x00..0x7c
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module apb_regif (
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  rf_pkg::apb_addr_t        paddr,
  input  rf_pkg::word_t            pwdata,
  input  rf_pkg::byte_en_t         pstrb,
  input  rf_pkg::lock_vec_t        lock [`RF_NUM_BANKS],
  output logic                     pready,
  output logic                     pslverr,
  output logic [`RF_NUM_BANKS-1:0] wr_bank,
  output rf_pkg::local_idx_t       wr_idx,
  output rf_pkg::word_t            wr_data,
  output rf_pkg::byte_en_t         wr_strb,
  output rf_pkg::word_t            lock_set,
  output logic                     lock_set_en,
  output rf_pkg::reg_idx_t         apb_idx,
  output logic                     apb_lock_sel
);

  logic               access;
  logic               entry_sel;
  logic               lock_sel;
  logic               addr_err;
  rf_pkg::reg_idx_t   idx;
  rf_pkg::bank_sel_t  bank;
  rf_pkg::local_idx_t loc_idx;
  logic               is_x0;
  logic               locked;
  logic               lock_err;
  logic               wr_ok;

  assign access = psel & penable; // second phase of the transfer

  assign idx     = paddr[6:2];
  assign bank    = idx[4:3];
  assign loc_idx = idx[2:0];
  assign is_x0   = (idx == '0);

  assign entry_sel = ~paddr[7] & (paddr[1:0] == 2'b00);
  assign lock_sel  = (paddr == `RF_LOCK_ADDR);
  assign addr_err  = ~entry_sel & ~lock_sel;

  assign locked   = lock[bank][loc_idx];
  assign lock_err = pwrite & entry_sel & ~is_x0 & locked; // x0 drops silently

  assign wr_ok = access & pwrite & entry_sel & ~is_x0 & ~locked;

  assign pready  = access;
  assign pslverr = access & (addr_err | lock_err);

  always_comb begin
    wr_bank = '0;
    if (wr_ok) begin
      wr_bank[bank] = 1'b1; // one hot bank strobe
    end
  end

  assign wr_idx  = loc_idx;
  assign wr_data = pwdata;
  assign wr_strb = wr_ok ? pstrb : '0;

  // lock writes ignore pstrb and only ever set bits
  assign lock_set    = pwdata;
  assign lock_set_en = access & pwrite & lock_sel;

  assign apb_idx      = idx;
  assign apb_lock_sel = lock_sel;

endmodule

// File: logic/reg_bank.sv
// ========================================
// eight entries with byte merge and locks
// lock bits only clear on reset
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module reg_bank #(
  parameter int NUM_TAPS = `RF_NUM_READ_PORTS + 1
) (
  input  logic               gated_clk,
  input  logic               rst_n,
  input  logic               wr_en,
  input  rf_pkg::local_idx_t wr_idx,
  input  rf_pkg::word_t      wr_data,
  input  rf_pkg::byte_en_t   wr_strb,
  input  rf_pkg::lock_vec_t  lock_set,
  input  logic               lock_set_en,
  input  rf_pkg::local_idx_t rd_idx [NUM_TAPS],
  output rf_pkg::word_t      rd_data [NUM_TAPS],
  output rf_pkg::lock_vec_t  lock
);

  rf_pkg::word_t mem [`RF_REGS_PER_BANK];
  rf_pkg::word_t merged;

  // unstrobed lanes keep the old bytes
  always_comb begin
    merged = mem[wr_idx];
    for (int b = 0; b < $bits(rf_pkg::byte_en_t); b++) begin
      if (wr_strb[b]) begin
        merged[8*b +: 8] = wr_data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge gated_clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RF_REGS_PER_BANK; i++) begin
        mem[i] <= '0;
      end
      lock <= '0;
    end else begin
      if (wr_en) begin
        mem[wr_idx] <= merged;
      end
      if (lock_set_en) begin
        lock <= lock | lock_set; // sticky
      end
    end
  end

  for (genvar t = 0; t < NUM_TAPS; t++) begin : g_taps
    assign rd_data[t] = mem[rd_idx[t]];
  end

endmodule

// File: logic/read_xbar.sv
// ========================================
// combinational read select across banks
// last tap of every bank serves apb
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module read_xbar #(
  parameter int NUM_TAPS = `RF_NUM_READ_PORTS + 1
) (
  input  rf_pkg::reg_idx_t   rs_addr [`RF_NUM_READ_PORTS],
  input  rf_pkg::reg_idx_t   apb_idx,
  input  logic               apb_lock_sel,
  input  logic               apb_err,
  input  rf_pkg::word_t      bank_data [`RF_NUM_BANKS][NUM_TAPS],
  input  rf_pkg::lock_vec_t  lock [`RF_NUM_BANKS],
  output rf_pkg::local_idx_t rd_idx [NUM_TAPS],
  output rf_pkg::word_t      rs_data [`RF_NUM_READ_PORTS],
  output rf_pkg::word_t      prdata
);

  localparam int APB_TAP = NUM_TAPS - 1;

  rf_pkg::bank_sel_t apb_bank;
  rf_pkg::word_t     apb_entry;
  rf_pkg::word_t     lock_word;

  for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_rs
    rf_pkg::bank_sel_t rs_bank;

    assign rs_bank    = rs_addr[p][4:3];
    assign rd_idx[p]  = rs_addr[p][2:0]; // same local index to all banks
    assign rs_data[p] = bank_data[rs_bank][p];
  end

  assign apb_bank        = apb_idx[4:3];
  assign rd_idx[APB_TAP] = apb_idx[2:0];
  assign apb_entry       = bank_data[apb_bank][APB_TAP];

  // bank n supplies lock bits 8n+7..8n
  always_comb begin
    lock_word = '0;
    for (int b = 0; b < `RF_NUM_BANKS; b++) begin
      lock_word[`RF_REGS_PER_BANK*b +: `RF_REGS_PER_BANK] = lock[b];
    end
  end

  always_comb begin
    if (apb_lock_sel) begin
      prdata = lock_word;
    end else if (apb_err) begin
      prdata = '0; // unmapped reads return zero
    end else begin
      prdata = apb_entry;
    end
  end

endmodule

// File: logic/rf_top.sv
// ========================================
// 32x32 register file, apb plus 2 reads
// gated_clk arrives already gated
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_top (
  input  logic              gated_clk,
  input  logic              rst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  rf_pkg::apb_addr_t paddr,
  input  rf_pkg::word_t     pwdata,
  input  rf_pkg::byte_en_t  pstrb,
  output rf_pkg::word_t     prdata,
  output logic              pready,
  output logic              pslverr,
  input  rf_pkg::reg_idx_t  rs_addr [`RF_NUM_READ_PORTS],
  output rf_pkg::word_t     rs_data [`RF_NUM_READ_PORTS]
);

  localparam int NUM_TAPS = `RF_NUM_READ_PORTS + 1; // rs ports plus apb

  logic [`RF_NUM_BANKS-1:0] wr_bank;
  rf_pkg::local_idx_t       wr_idx;
  rf_pkg::word_t            wr_data;
  rf_pkg::byte_en_t         wr_strb;
  rf_pkg::word_t            lock_set;
  logic                     lock_set_en;
  rf_pkg::reg_idx_t         apb_idx;
  logic                     apb_lock_sel;
  rf_pkg::lock_vec_t        lock [`RF_NUM_BANKS];
  rf_pkg::word_t            bank_data [`RF_NUM_BANKS][NUM_TAPS];
  rf_pkg::local_idx_t       rd_idx [NUM_TAPS];

  apb_regif regif_i (
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pstrb        (pstrb),
    .lock         (lock),
    .pready       (pready),
    .pslverr      (pslverr),
    .wr_bank      (wr_bank),
    .wr_idx       (wr_idx),
    .wr_data      (wr_data),
    .wr_strb      (wr_strb),
    .lock_set     (lock_set),
    .lock_set_en  (lock_set_en),
    .apb_idx      (apb_idx),
    .apb_lock_sel (apb_lock_sel)
  );

  for (genvar b = 0; b < `RF_NUM_BANKS; b++) begin : g_banks
    reg_bank #(
      .NUM_TAPS (NUM_TAPS)
    ) bank_i (
      .gated_clk   (gated_clk),
      .rst_n       (rst_n),
      .wr_en       (wr_bank[b]),
      .wr_idx      (wr_idx),
      .wr_data     (wr_data),
      .wr_strb     (wr_strb),
      .lock_set    (lock_set[`RF_REGS_PER_BANK*b +: `RF_REGS_PER_BANK]),
      .lock_set_en (lock_set_en),
      .rd_idx      (rd_idx),
      .rd_data     (bank_data[b]),
      .lock        (lock[b])
    );
  end

  // unmapped reads zero prdata through pslverr
  read_xbar #(
    .NUM_TAPS (NUM_TAPS)
  ) xbar_i (
    .rs_addr      (rs_addr),
    .apb_idx      (apb_idx),
    .apb_lock_sel (apb_lock_sel),
    .apb_err      (pslverr),
    .bank_data    (bank_data),
    .lock         (lock),
    .rd_idx       (rd_idx),
    .rs_data      (rs_data),
    .prdata       (prdata)
  );

endmodule

// File: bench/rf_chk.sv
// ========================================
// apb and x0 assertions, bound to rf_top
// fail_count is read by the testbench
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_chk (
  input logic             gated_clk,
  input logic             rst_n,
  input logic             psel,
  input logic             penable,
  input logic             pready,
  input logic             pslverr,
  input rf_pkg::reg_idx_t rs_addr [`RF_NUM_READ_PORTS],
  input rf_pkg::word_t    rs_data [`RF_NUM_READ_PORTS]
);

  int fail_count = 0;

  a_pready_access: assert property (@(posedge gated_clk) disable iff (!rst_n)
    pready |-> (psel && penable && $past(psel && !penable))) // access follows setup
    else begin
      fail_count = fail_count + 1;
      $error("pready outside an access cycle");
    end

  a_slverr_ready: assert property (@(posedge gated_clk) disable iff (!rst_n)
    pslverr |-> pready)
    else begin
      fail_count = fail_count + 1;
      $error("pslverr without pready");
    end

  for (genvar p = 0; p < `RF_NUM_READ_PORTS; p++) begin : g_x0
    a_x0_zero: assert property (@(posedge gated_clk) disable iff (!rst_n)
      (rs_addr[p] == '0) |-> (rs_data[p] == '0))
      else begin
        fail_count = fail_count + 1;
        $error("x0 read nonzero on rs port %0d", p);
      end
  end

endmodule

// File: bench/rf_tb.sv
// ========================================
// directed apb and rs port tests
// model assumes zero wait state apb
// ========================================
`timescale 1ns/1ps
`include "rf_macros.svh"

module rf_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 3;
  localparam int XFERS        = 33 + 62 + 17 + 2 + 15 + 5; // apb transfers per test
  localparam int TIMEOUT_NS   = (XFERS * 40 + RESET_CYCLES + 10) * CLK_PERIOD;

  logic              gated_clk;
  logic              rst_n;
  logic              psel;
  logic              penable;
  logic              pwrite;
  rf_pkg::apb_addr_t paddr;
  rf_pkg::word_t     pwdata;
  rf_pkg::byte_en_t  pstrb;
  rf_pkg::word_t     prdata;
  logic              pready;
  logic              pslverr;
  rf_pkg::reg_idx_t  rs_addr [`RF_NUM_READ_PORTS];
  rf_pkg::word_t     rs_data [`RF_NUM_READ_PORTS];

  rf_pkg::word_t model [32];
  rf_pkg::word_t model_lock;
  logic [31:0]   lcg_state = 32'he76ead84;

  bind rf_top rf_chk chk_i (
    .gated_clk (gated_clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .rs_addr   (rs_addr),
    .rs_data   (rs_data)
  );

  rf_top dut_i (
    .gated_clk (gated_clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .pstrb     (pstrb),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rs_addr   (rs_addr),
    .rs_data   (rs_data)
  );

  always #(CLK_PERIOD / 2) gated_clk = ~gated_clk;

  function automatic rf_pkg::word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic rf_pkg::apb_addr_t entry_addr(input int idx);
    return rf_pkg::apb_addr_t'(idx * 4);
  endfunction

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string name);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, actual, expected);
      $display("Something failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // model update and expected response of one transfer
  task automatic model_access(input logic write, input rf_pkg::apb_addr_t addr,
                              input rf_pkg::word_t data, input rf_pkg::byte_en_t strb,
                              output logic exp_err, output rf_pkg::word_t exp_rdata);
    rf_pkg::reg_idx_t idx;
    idx       = addr[6:2];
    exp_err   = 1'b0;
    exp_rdata = '0;
    if (addr == `RF_LOCK_ADDR) begin
      if (write) begin
        model_lock = model_lock | data; // strobes ignored
      end else begin
        exp_rdata = model_lock;
      end
    end else if (addr < 8'h80 && addr[1:0] == 2'b00) begin
      if (!write) begin
        exp_rdata = model[idx];
      end else if (idx != 0 && model_lock[idx]) begin
        exp_err = 1'b1;
      end else if (idx != 0) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            model[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
    end else begin
      exp_err = 1'b1; // unmapped
    end
  endtask

  task automatic apb_transfer(input logic write, input rf_pkg::apb_addr_t addr,
                              input rf_pkg::word_t data, input rf_pkg::byte_en_t strb,
                              output rf_pkg::word_t rdata, output logic err);
    @(posedge gated_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= data;
    pstrb   <= strb;
    @(negedge gated_clk);
    check_eq(pready, 1'b0, "pready in setup");
    @(posedge gated_clk);
    penable <= 1'b1;
    @(negedge gated_clk);
    check_eq(pready, 1'b1, "pready in access");
    rdata = prdata;
    err   = pslverr;
    @(posedge gated_clk); // commit edge
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_write(input rf_pkg::apb_addr_t addr, input rf_pkg::word_t data,
                           input rf_pkg::byte_en_t strb);
    rf_pkg::word_t rdata;
    rf_pkg::word_t exp_rdata;
    logic          err;
    logic          exp_err;
    apb_transfer(1'b1, addr, data, strb, rdata, err);
    model_access(1'b1, addr, data, strb, exp_err, exp_rdata);
    check_eq(err, exp_err, "pslverr");
  endtask

  task automatic apb_read(input rf_pkg::apb_addr_t addr);
    rf_pkg::word_t rdata;
    rf_pkg::word_t exp_rdata;
    logic          err;
    logic          exp_err;
    apb_transfer(1'b0, addr, '0, '0, rdata, err);
    model_access(1'b0, addr, '0, '0, exp_err, exp_rdata);
    check_eq(err, exp_err, "pslverr");
    check_eq(rdata, exp_rdata, "prdata");
  endtask

  task automatic rs_check(input int a, input int b);
    @(posedge gated_clk);
    rs_addr[0] <= rf_pkg::reg_idx_t'(a);
    rs_addr[1] <= rf_pkg::reg_idx_t'(b);
    @(negedge gated_clk);
    check_eq(rs_data[0], model[a], "rs_data[0]");
    check_eq(rs_data[1], model[b], "rs_data[1]");
  endtask

  task automatic reset_values();
    for (int i = 0; i < 32; i++) begin
      rs_check(i, 31 - i);
      apb_read(entry_addr(i));
    end
    apb_read(`RF_LOCK_ADDR);
  endtask

  task automatic word_writes();
    for (int i = 1; i < 32; i++) begin
      apb_write(entry_addr(i), next_rand(), 4'hf);
    end
    for (int i = 1; i < 32; i++) begin
      rs_check(i, 32 - i);
      apb_read(entry_addr(i));
    end
  endtask

  task automatic partial_writes();
    rf_pkg::byte_en_t pats [8];
    pats = '{4'b0001, 4'b0100, 4'b0011, 4'b1100, 4'b1010, 4'b0101, 4'b0110, 4'b0000};
    apb_write(entry_addr(5), 32'h11223344, 4'hf); // known prior value
    for (int k = 0; k < 8; k++) begin
      apb_write(entry_addr(5), next_rand(), pats[k]);
      apb_read(entry_addr(5));
    end
    rs_check(5, 4);
  endtask

  task automatic x0_hardwired();
    apb_write(entry_addr(0), 32'hffffffff, 4'hf);
    apb_read(entry_addr(0));
    rs_check(0, 0);
  endtask

  task automatic lock_behavior();
    int locked [4];
    int open [2];
    locked = '{2, 8, 9, 16};
    open   = '{3, 17};
    apb_write(`RF_LOCK_ADDR, 32'h0000_0304, 4'hf);
    apb_write(`RF_LOCK_ADDR, 32'h0001_0200, 4'h0); // overlaps entry 9
    apb_read(`RF_LOCK_ADDR);
    for (int k = 0; k < 4; k++) begin
      apb_write(entry_addr(locked[k]), next_rand(), 4'hf);
      apb_read(entry_addr(locked[k]));
    end
    for (int k = 0; k < 2; k++) begin
      apb_write(entry_addr(open[k]), next_rand(), 4'hf);
      apb_read(entry_addr(open[k]));
    end
  endtask

  task automatic bad_address();
    apb_write(8'h84, next_rand(), 4'hf);
    apb_read(8'h84);
    apb_read(8'h02);
    apb_read(8'hfc);
    apb_read(entry_addr(1)); // 0x84 aliases entry 1 in paddr[6:2]
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    gated_clk  = 1'b0;
    rst_n      = 1'b0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    pstrb      = '0;
    rs_addr[0] = '0;
    rs_addr[1] = '0;
    model_lock = '0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge gated_clk);
    rst_n <= 1'b1;
    reset_values();
    word_writes();
    partial_writes();
    x0_hardwired();
    lock_behavior();
    bad_address();
    @(posedge gated_clk);
    if (dut_i.chk_i.fail_count != 0) begin
      $display("protocol assertions failed %0d times", dut_i.chk_i.fail_count);
      $display("Something failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: sources.f
+incdir+include
logic/rf_pkg.sv
logic/apb_regif.sv
logic/reg_bank.sv
logic/read_xbar.sv
logic/rf_top.sv
bench/rf_chk.sv
bench/rf_tb.sv
